//--- Makefile
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/pipeline_control.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/execute_unit.sv
rtl/data_memory.sv
rtl/rv_core.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv

//--- rtl/data_memory.sv
/*
 * Memory stage: word data RAM, writeback select, MEM/WB register and commit record.
 */
`timescale 1ns/1ns
`default_nettype none

module data_memory
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  ex_mem_t mem_stage,
  input  logic    mem_valid,
  input  logic    wb_valid,
  output word_t   mem_result,
  output commit_t commit
);

  word_t              dmem [dmem_depth];
  logic [dmem_aw-1:0] index;
  logic               we_q;
  word_t              pc_q;
  reg_addr_t          rd_q;
  word_t              data_q;

  // aligned words only
  assign index      = mem_stage.result[dmem_aw+1:2];
  assign mem_result = mem_stage.result;

  always_ff @(posedge clock) begin
    if (mem_valid && mem_stage.is_store) begin
      dmem[index] <= mem_stage.store_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      we_q <= 1'b0;
    end else if (mem_valid) begin
      we_q <= mem_stage.rd_we;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid) begin
      pc_q   <= mem_stage.pc;
      rd_q   <= mem_stage.rd;
      data_q <= mem_stage.is_load ? dmem[index] : mem_stage.result;
    end
  end

  assign commit = '{valid: wb_valid, pc: pc_q, rd_we: wb_valid && we_q, rd: rd_q, data: data_q};

endmodule

`default_nettype wire

//--- rtl/decoder.sv
/*
 * Decode stage: splits the instruction into control and immediate,
 * collects register operands and holds the ID/EX register.
 */
`timescale 1ns/1ns
`default_nettype none

module decoder
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic      clock,
  input  word_t     id_pc,
  input  inst_u     id_inst,
  input  logic      ex_load,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output id_ex_t    ex_stage
);

  id_ex_t dec;
  word_t  imm_i;
  word_t  imm_s;
  word_t  imm_b;
  word_t  imm_u;

  assign imm_i = {{20{id_inst.i_fmt.imm[11]}}, id_inst.i_fmt.imm};
  assign imm_s = {{20{id_inst.s_fmt.imm_hi[6]}}, id_inst.s_fmt.imm_hi, id_inst.s_fmt.imm_lo};
  assign imm_b = {{20{id_inst.b_fmt.imm_12}}, id_inst.b_fmt.imm_11, id_inst.b_fmt.imm_10_5,
                  id_inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {id_inst.u_fmt.imm, 12'b0};

  // unused source fields stay zero so they never trip a stall
  always_comb begin
    dec    = '0;
    dec.pc = id_pc;
    case (id_inst.r_fmt.opcode)
      opc_op: begin
        dec.rs1   = id_inst.r_fmt.rs1;
        dec.rs2   = id_inst.r_fmt.rs2;
        dec.rd    = id_inst.r_fmt.rd;
        dec.rd_we = 1'b1;
        case (id_inst.r_fmt.funct3)
          f3_add_sub: dec.alu_op = (id_inst.r_fmt.funct7 == f7_sub) ? alu_sub : alu_add;
          f3_slt:     dec.alu_op = alu_slt;
          f3_xor:     dec.alu_op = alu_xor;
          f3_or:      dec.alu_op = alu_or;
          f3_and:     dec.alu_op = alu_and;
          default:    dec.rd_we  = 1'b0;
        endcase
      end
      opc_op_imm, opc_load: begin
        // only addi and lw in the subset
        if (id_inst.i_fmt.funct3 == (id_inst.i_fmt.opcode == opc_load ? f3_word : f3_add_sub)) begin
          dec.rs1      = id_inst.i_fmt.rs1;
          dec.rd       = id_inst.i_fmt.rd;
          dec.rd_we    = 1'b1;
          dec.b_is_imm = 1'b1;
          dec.imm      = imm_i;
          dec.is_load  = (id_inst.i_fmt.opcode == opc_load);
        end
      end
      opc_lui: begin
        dec.rd       = id_inst.u_fmt.rd;
        dec.rd_we    = 1'b1;
        dec.alu_op   = alu_pass_b;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_u;
      end
      opc_store: begin
        if (id_inst.s_fmt.funct3 == f3_word) begin
          dec.rs1      = id_inst.s_fmt.rs1;
          dec.rs2      = id_inst.s_fmt.rs2;
          dec.is_store = 1'b1;
          dec.b_is_imm = 1'b1;
          dec.imm      = imm_s;
        end
      end
      opc_branch: begin
        if (id_inst.b_fmt.funct3 == f3_beq || id_inst.b_fmt.funct3 == f3_bne) begin
          dec.rs1       = id_inst.b_fmt.rs1;
          dec.rs2       = id_inst.b_fmt.rs2;
          dec.is_branch = 1'b1;
          dec.br_ne     = (id_inst.b_fmt.funct3 == f3_bne);
          dec.imm       = imm_b;
        end
      end
      default: ;
    endcase
  end

  assign rs1 = dec.rs1;
  assign rs2 = dec.rs2;

  always_ff @(posedge clock) begin
    if (ex_load) begin
      ex_stage          <= dec;
      ex_stage.rs1_data <= rs1_data;
      ex_stage.rs2_data <= rs2_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
/*
 * Execute stage: forwarded operands, ALU, BEQ/BNE resolution and EX/MEM register.
 */
`timescale 1ns/1ns
`default_nettype none

module execute_unit
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic     clock,
  input  id_ex_t   ex_stage,
  input  logic     ex_valid,
  input  fwd_sel_t fwd_a,
  input  fwd_sel_t fwd_b,
  input  word_t    mem_result,
  input  word_t    wb_result,
  output logic     branch_taken,
  output word_t    branch_target,
  output ex_mem_t  mem_stage
);

  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t result;

  function automatic word_t pick_operand(fwd_sel_t sel, word_t reg_val,
                                         word_t mem_val, word_t wb_val);
    case (sel)
      from_mem: return mem_val;
      from_wb:  return wb_val;
      default:  return reg_val;
    endcase
  endfunction

  assign op_a    = pick_operand(fwd_a, ex_stage.rs1_data, mem_result, wb_result);
  assign rs2_val = pick_operand(fwd_b, ex_stage.rs2_data, mem_result, wb_result);
  assign op_b    = ex_stage.b_is_imm ? ex_stage.imm : rs2_val;

  always_comb begin
    case (ex_stage.alu_op)
      alu_sub:    result = op_a - op_b;
      alu_and:    result = op_a & op_b;
      alu_or:     result = op_a | op_b;
      alu_xor:    result = op_a ^ op_b;
      alu_slt:    result = word_t'($signed(op_a) < $signed(op_b));
      alu_pass_b: result = op_b;
      default:    result = op_a + op_b;
    endcase
  end

  // bne takes the branch when operands differ
  assign branch_taken  = ex_valid && ex_stage.is_branch &&
                         ((op_a == rs2_val) != ex_stage.br_ne);
  assign branch_target = ex_stage.pc + ex_stage.imm;

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      mem_stage <= '{pc: ex_stage.pc, rd: ex_stage.rd, rd_we: ex_stage.rd_we,
                     is_load: ex_stage.is_load, is_store: ex_stage.is_store,
                     result: result, store_data: rs2_val};
    end
  end

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
/*
 * Fetch stage: program counter, boot-loaded instruction RAM and IF/ID register.
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  boot_t boot,
  input  logic  if_hold,
  input  logic  id_load,
  input  logic  branch_taken,
  input  word_t branch_target,
  output word_t id_pc,
  output inst_u id_inst
);

  word_t pc;
  word_t imem [imem_depth];

  // program image arrives over the boot port
  always_ff @(posedge clock) begin
    if (boot.wr_ena) begin
      imem[boot.addr] <= boot.inst;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= pc_start;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!if_hold) begin
      pc <= pc + word_t'(4);
    end
  end

  always_ff @(posedge clock) begin
    if (id_load) begin
      id_pc   <= pc;
      id_inst <= imem[pc[imem_aw+1:2]];
    end
  end

endmodule

`default_nettype wire

//--- rtl/isa_pkg.sv
/*
 * RV32I subset definitions shared by every pipeline stage.
 * Widths, memory sizes, opcodes, funct codes and the instruction word views.
 */
`default_nettype none

package isa_pkg;

  localparam int xlen       = 32;
  localparam int imem_depth = 64;
  localparam int dmem_depth = 64;
  localparam int imem_aw    = $clog2(imem_depth);
  localparam int dmem_aw    = $clog2(dmem_depth);

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  localparam word_t pc_start = 32'h0000_0000;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011
  } opcode_t;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  // lw and sw both use the word size code
  localparam logic [2:0] f3_word    = 3'b010;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [6:0] f7_sub     = 7'b0100000;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } inst_u;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
/*
 * Pipeline payloads passed between stages, the boot write port,
 * the per-instruction commit record and the operand forward selects.
 */
`default_nettype none

package pipe_pkg;

  import isa_pkg::*;

  typedef struct packed {
    logic               wr_ena;
    logic [imem_aw-1:0] addr;
    word_t              inst;
  } boot_t;

  typedef struct packed {
    word_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      rd_we;
    alu_op_t   alu_op;
    logic      b_is_imm;
    word_t     imm;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      br_ne;
    word_t     rs1_data;
    word_t     rs2_data;
  } id_ex_t;

  typedef struct packed {
    word_t     pc;
    reg_addr_t rd;
    logic      rd_we;
    logic      is_load;
    logic      is_store;
    word_t     result;
    word_t     store_data;
  } ex_mem_t;

  // rd_we already qualified by valid
  typedef struct packed {
    logic      valid;
    word_t     pc;
    logic      rd_we;
    reg_addr_t rd;
    word_t     data;
  } commit_t;

  typedef enum logic [1:0] {
    from_reg,
    from_mem,
    from_wb
  } fwd_sel_t;

endpackage

`default_nettype wire

//--- rtl/pipeline_control.sv
/*
 * Stage valid bits and the allowin chain of the five-stage pipeline.
 * Also resolves load-use stalls, branch squash and EX operand forwarding.
 */
`timescale 1ns/1ns
`default_nettype none

module pipeline_control
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      run,
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  id_ex_t    ex_stage,
  input  ex_mem_t   mem_stage,
  input  commit_t   wb_commit,
  input  logic      branch_taken,
  output logic      if_hold,
  output logic      id_valid,
  output logic      id_load,
  output logic      ex_valid,
  output logic      ex_load,
  output logic      mem_valid,
  output logic      wb_valid,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b
);

  logic id_allowin;
  logic id_ready_go;
  logic load_use;

  function automatic fwd_sel_t pick_source(reg_addr_t rs);
    // MEM is younger, so it wins over WB
    if (mem_valid && mem_stage.rd_we &&
        mem_stage.rd != '0 && mem_stage.rd == rs) begin
      return from_mem;
    end
    if (wb_commit.rd_we && wb_commit.rd != '0 && wb_commit.rd == rs) begin
      return from_wb;
    end
    return from_reg;
  endfunction

  // loaded value is not ready until WB
  assign load_use = id_valid && ex_valid && ex_stage.is_load && ex_stage.rd_we &&
                    ex_stage.rd != '0 &&
                    (ex_stage.rd == id_rs1 || ex_stage.rd == id_rs2);

  // only the load-use stall blocks ID
  assign id_ready_go = !load_use;
  assign id_allowin  = !id_valid || id_ready_go;

  assign if_hold = !run || !id_allowin;
  assign id_load = id_allowin;
  assign ex_load = id_valid && id_ready_go;

  always_ff @(posedge clock) begin
    if (reset || branch_taken) begin
      id_valid <= 1'b0;
      ex_valid <= 1'b0;
    end else begin
      if (id_allowin) begin
        id_valid <= run;
      end
      // bubble into EX on a stall
      ex_valid <= id_valid && id_ready_go;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
      wb_valid  <= mem_valid;
    end
  end

  always_comb begin
    fwd_a = pick_source(ex_stage.rs1);
    fwd_b = pick_source(ex_stage.rs2);
  end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
/*
 * Integer register file, two combinational reads and one write.
 * x0 reads zero; a read of the register being written returns the new value.
 */
`timescale 1ns/1ns
`default_nettype none

module regfile
  import isa_pkg::*;
(
  input  logic      clock,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      wr_ena,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data
);

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (wr_ena && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // WB write bypasses straight into decode
  assign rs1_data = (rs1 == '0) ? '0 : (wr_ena && wr_addr == rs1) ? wr_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (wr_ena && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
/*
 * Five-stage RV32I subset core. Load the program over boot with run low,
 * then raise run; each retired instruction shows up once on commit.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_core
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    run,
  input  boot_t   boot,
  output commit_t commit
);

  // stage control
  logic     if_hold;
  logic     id_load;
  logic     ex_load;
  logic     ex_valid;
  logic     mem_valid;
  logic     wb_valid;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;

  // datapath
  word_t     id_pc;
  inst_u     id_inst;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  id_ex_t    ex_stage;
  ex_mem_t   mem_stage;
  word_t     mem_result;
  logic      branch_taken;
  word_t     branch_target;

  // id_valid is watched only inside the control block
  pipeline_control u_control (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .id_rs1       (rs1),
    .id_rs2       (rs2),
    .ex_stage     (ex_stage),
    .mem_stage    (mem_stage),
    .wb_commit    (commit),
    .branch_taken (branch_taken),
    .if_hold      (if_hold),
    .id_valid     (),
    .id_load      (id_load),
    .ex_valid     (ex_valid),
    .ex_load      (ex_load),
    .mem_valid    (mem_valid),
    .wb_valid     (wb_valid),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  fetch_unit u_fetch (
    .clock         (clock),
    .reset         (reset),
    .boot          (boot),
    .if_hold       (if_hold),
    .id_load       (id_load),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .id_pc         (id_pc),
    .id_inst       (id_inst)
  );

  decoder u_decoder (
    .clock    (clock),
    .id_pc    (id_pc),
    .id_inst  (id_inst),
    .ex_load  (ex_load),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex_stage (ex_stage)
  );

  regfile u_regfile (
    .clock    (clock),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_ena   (commit.rd_we),
    .wr_addr  (commit.rd),
    .wr_data  (commit.data)
  );

  execute_unit u_execute (
    .clock         (clock),
    .ex_stage      (ex_stage),
    .ex_valid      (ex_valid),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .mem_result    (mem_result),
    .wb_result     (commit.data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .mem_stage     (mem_stage)
  );

  data_memory u_memory (
    .clock      (clock),
    .reset      (reset),
    .mem_stage  (mem_stage),
    .mem_valid  (mem_valid),
    .wb_valid   (wb_valid),
    .mem_result (mem_result),
    .commit     (commit)
  );

endmodule

`default_nettype wire

//--- tests/rv_core_props.sv
/*
 * Concurrent checks on the pipeline control block, bound into
 * pipeline_control from the testbench.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_core_props
  import pipe_pkg::*;
(
  input logic     clock,
  input logic     reset,
  input logic     run,
  input logic     id_valid,
  input logic     ex_valid,
  input logic     mem_valid,
  input logic     wb_valid,
  input logic     if_hold,
  input logic     load_use,
  input logic     branch_taken,
  input ex_mem_t  mem_stage,
  input fwd_sel_t fwd_a
);

  // pipeline leaves reset empty
  empty_after_reset: assert property (@(posedge clock)
    reset |=> !(id_valid || ex_valid || mem_valid || wb_valid))
    else $error("a stage valid bit is set in the cycle after reset");

  squash_clears_ex: assert property (@(posedge clock) disable iff (reset)
    branch_taken |=> !ex_valid)
    else $error("ex_valid still set after a taken branch");

  stall_releases_fetch: assert property (@(posedge clock) disable iff (reset)
    run && load_use |=> !if_hold)
    else $error("if_hold lasted longer than one stall cycle");

  // a load in MEM has no data yet
  no_load_forward: assert property (@(posedge clock) disable iff (reset)
    ex_valid && mem_valid && mem_stage.is_load |-> fwd_a != from_mem)
    else $error("operand a forwarded from a load in MEM");

endmodule

`default_nettype wire

//--- tests/rv_core_tb.sv
/*
 * Testbench for rv_core. Boots a program with run low, raises run and checks
 * every commit record against a table built by a small RV32I reference model.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb
  import isa_pkg::*, pipe_pkg::*;
();

  localparam int period      = 40;
  localparam int drive_delay = 2;

  logic    clock;
  logic    reset;
  logic    run;
  boot_t   boot;
  commit_t commit;

  // one row per instruction word, in address order
  word_t       prog [$];
  commit_t     expect_q [$];
  word_t       model_regs [32];
  word_t       model_mem [dmem_depth];
  int          skip;
  logic [31:0] rng;
  int          next_row;
  int          checked;
  int          commit_total;
  int          cycles;
  int          cycle_limit;

  rv_core i_dut (
    .clock  (clock),
    .reset  (reset),
    .run    (run),
    .boot   (boot),
    .commit (commit)
  );

  bind pipeline_control rv_core_props i_props (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .id_valid     (id_valid),
    .ex_valid     (ex_valid),
    .mem_valid    (mem_valid),
    .wb_valid     (wb_valid),
    .if_hold      (if_hold),
    .load_use     (load_use),
    .branch_taken (branch_taken),
    .mem_stage    (mem_stage),
    .fwd_a        (fwd_a)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t ref_alu(logic [2:0] f3, logic sub, word_t a, word_t b);
    case (f3)
      f3_add_sub: return sub ? a - b : a + b;
      f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_xor:     return a ^ b;
      f3_or:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  task automatic stop_run(string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(word_t got, word_t exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_commit(commit_t got, commit_t exp);
    check_word(got.pc, exp.pc, "commit pc");
    if (got.rd_we !== exp.rd_we) begin
      stop_run($sformatf("Fail at %0t ns: write enable at pc %h is %b, expected %b",
                         $time, exp.pc, got.rd_we, exp.rd_we));
    end
    if (exp.rd_we) begin
      if (got.rd !== exp.rd) begin
        stop_run($sformatf("Fail at %0t ns: rd at pc %h is x%0d, expected x%0d",
                           $time, exp.pc, got.rd, exp.rd));
      end
      check_word(got.data, exp.data, $sformatf("x%0d at pc %h", exp.rd, exp.pc));
    end
  endtask

  // squashed rows leave the model untouched
  task automatic append_row(word_t inst, logic we, int rd, word_t value);
    commit_t row;
    row.valid = (skip == 0);
    row.pc    = pc_start + word_t'(4 * prog.size());
    row.rd_we = we;
    row.rd    = reg_addr_t'(rd);
    row.data  = value;
    if (skip > 0) begin
      skip--;
    end else if (we && rd != 0) begin
      model_regs[rd[4:0]] = value;
    end
    prog.push_back(inst);
    expect_q.push_back(row);
  endtask

  task automatic alu_reg(logic [2:0] f3, logic sub, int rd, int rs1, int rs2);
    word_t inst;
    inst = {sub ? f7_sub : 7'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
    append_row(inst, 1'b1, rd, ref_alu(f3, sub, model_regs[rs1[4:0]], model_regs[rs2[4:0]]));
  endtask

  task automatic alu_imm(int rd, int rs1, int imm);
    word_t inst;
    inst = {imm[11:0], rs1[4:0], f3_add_sub, rd[4:0], opc_op_imm};
    append_row(inst, 1'b1, rd, model_regs[rs1[4:0]] + {{20{imm[11]}}, imm[11:0]});
  endtask

  task automatic load_upper(int rd, int imm20);
    word_t inst;
    inst = {imm20[19:0], rd[4:0], opc_lui};
    append_row(inst, 1'b1, rd, {imm20[19:0], 12'h000});
  endtask

  task automatic store_word(int rs2, int rs1, int imm);
    word_t inst;
    word_t addr;
    inst = {imm[11:5], rs2[4:0], rs1[4:0], f3_word, imm[4:0], opc_store};
    addr = model_regs[rs1[4:0]] + {{20{imm[11]}}, imm[11:0]};
    if (skip == 0) begin
      model_mem[addr[dmem_aw+1:2]] = model_regs[rs2[4:0]];
    end
    append_row(inst, 1'b0, 0, addr);
  endtask

  task automatic load_word(int rd, int rs1, int imm);
    word_t inst;
    word_t addr;
    inst = {imm[11:0], rs1[4:0], f3_word, rd[4:0], opc_load};
    addr = model_regs[rs1[4:0]] + {{20{imm[11]}}, imm[11:0]};
    append_row(inst, 1'b1, rd, model_mem[addr[dmem_aw+1:2]]);
  endtask

  // target is pc + 12, just past the two squashed words
  task automatic branch_cmp(logic ne, int rs1, int rs2);
    logic [12:0] off;
    word_t       inst;
    logic        taken;
    off   = 13'd12;
    inst  = {off[12], off[10:5], rs2[4:0], rs1[4:0], ne ? f3_bne : f3_beq,
             off[4:1], off[11], opc_branch};
    taken = (skip == 0) && ((model_regs[rs1[4:0]] == model_regs[rs2[4:0]]) != ne);
    append_row(inst, 1'b0, 0, 32'd0);
    if (taken) begin
      skip = 2;
    end
  endtask

  task automatic build_program();
    int rd;
    int rs1;
    int rs2;
    // dependent chain through MEM and WB forwarding
    alu_imm(1, 0, 5);
    alu_imm(2, 0, -3);
    alu_reg(f3_add_sub, 1'b0, 3, 1, 2);
    alu_reg(f3_add_sub, 1'b1, 4, 3, 1);
    alu_reg(f3_and, 1'b0, 5, 4, 1);
    alu_reg(f3_or, 1'b0, 6, 5, 4);
    alu_reg(f3_xor, 1'b0, 7, 6, 3);
    alu_reg(f3_slt, 1'b0, 8, 2, 1);
    alu_reg(f3_slt, 1'b0, 9, 1, 2);
    load_upper(10, 20'h12345);
    alu_imm(10, 10, 12'h678);
    // store, load back, use right behind the load
    store_word(10, 0, 8);
    load_word(11, 0, 8);
    alu_reg(f3_add_sub, 1'b0, 12, 11, 1);
    store_word(3, 0, 12);
    load_word(13, 0, 12);
    alu_imm(14, 13, 1);
    store_word(0, 0, 16);
    // x0 takes the write but reads back zero
    alu_imm(0, 0, 7);
    alu_reg(f3_add_sub, 1'b0, 15, 0, 1);
    branch_cmp(1'b0, 1, 1);
    alu_imm(16, 0, 1);
    alu_imm(17, 0, 2);
    branch_cmp(1'b1, 1, 2);
    store_word(1, 0, 16);
    alu_imm(17, 0, 3);
    branch_cmp(1'b0, 1, 2);
    alu_imm(18, 0, 9);
    branch_cmp(1'b1, 1, 1);
    alu_reg(f3_add_sub, 1'b0, 19, 18, 1);
    // still zero if the squashed store never landed
    load_word(19, 0, 16);
    for (int r = 20; r < 28; r++) begin
      rng = xorshift32(rng);
      alu_imm(r, 0, int'(rng[31:20]));
    end
    for (int n = 0; n < 12; n++) begin
      rng = xorshift32(rng);
      rd  = 20 + int'(rng[2:0]);
      rs1 = 20 + int'(rng[5:3]);
      rs2 = 20 + int'(rng[8:6]);
      if (rng[9]) begin
        alu_imm(rd, rs1, int'(rng[31:20]));
      end else begin
        alu_reg(f3_add_sub, 1'b0, rd, rs1, rs2);
      end
    end
  endtask

  initial begin
    reset    = 1'b1;
    run      = 1'b0;
    boot     = '0;
    skip     = 0;
    rng      = 32'h25a1;
    next_row = 0;
    checked  = 0;
    cycles   = 0;
    foreach (model_regs[i]) model_regs[i] = '0;
    foreach (model_mem[i]) model_mem[i] = '0;
    build_program();
    commit_total = 0;
    foreach (expect_q[i]) begin
      if (expect_q[i].valid) commit_total++;
    end
    cycle_limit = 8 * prog.size() + 100;
    repeat (4) @(posedge clock);
    #drive_delay reset = 1'b0;
    foreach (prog[i]) begin
      @(posedge clock);
      #drive_delay boot = '{wr_ena: 1'b1, addr: imem_aw'(i), inst: prog[i]};
    end
    @(posedge clock);
    #drive_delay boot = '0;
    // idle with run low, no commit may show up
    repeat (5) @(posedge clock);
    #drive_delay run = 1'b1;
    wait (checked == commit_total);
    @(posedge clock);
    $display("Simulation passed");
    $finish;
  end

  // commit is registered, so sample it mid-cycle
  always @(negedge clock) begin
    if (!reset && commit.valid === 1'b1) begin
      if (!run) begin
        stop_run("a commit appeared while run was low");
      end else if (checked < commit_total) begin
        while (!expect_q[next_row].valid) next_row++;
        check_commit(commit, expect_q[next_row]);
        next_row++;
        checked++;
      end
    end
  end

  always @(posedge clock) begin
    if (run) begin
      cycles++;
      if (cycles > cycle_limit) begin
        stop_run("commit stream stopped before the program ended");
      end
    end
  end

endmodule

`default_nettype wire
